//--- source/ddr_pkg.sv
package ddr_pkg;

	// channel geometry
	localparam int num_bursts = 4;   // burst slots in the handler
	localparam int burst_len  = 16;  // beats per burst
	localparam int data_width = 16;  // bits per beat

	// memory timing in clk cycles
	localparam int rd_to_data = 11;  // second read cmd cycle to first read beat
	localparam int wr_to_data = 8;   // second write cmd cycle to first write beat
	localparam int t_rcd      = 4;   // activate to column command
	localparam int t_rp       = 4;   // precharge to next activate

	localparam int ret_depth = 4;    // response queue entries

	typedef logic [data_width-1:0] data_t;
	typedef logic [3:0]            index_t;  // request tag
	typedef logic [29:0]           addr_t;   // bg(2) bank(2) row(16) col(10)
	typedef logic [25:0]           block_t;  // addr_t without the beat bits
	typedef logic [1:0]            burst_id_t;
	typedef logic                  kind_t;   // 0 read, 1 write

	typedef enum logic [2:0] {
		empty,
		filling,
		full,
		issued,
		returning
	} burst_state_e;

	typedef enum logic [2:0] {
		none,
		activate,
		read_cmd,
		write_cmd,
		precharge
	} mem_cmd_e;

	typedef enum logic [2:0] {
		idle,
		act,
		act_wait,
		col,
		data_phase,
		pre,
		pre_wait
	} ctl_state_e;

endpackage

//--- source/burst_handler.sv
`timescale 1ns/1ps

module burst_handler (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  logic                                            req_valid,
	output logic                                            req_ready,
	input  ddr_pkg::kind_t                                  req_kind,
	input  ddr_pkg::addr_t                                  req_addr,
	input  ddr_pkg::data_t                                  req_data,
	input  ddr_pkg::index_t                                 req_index,
	output ddr_pkg::burst_state_e [ddr_pkg::num_bursts-1:0] slot_state,
	output ddr_pkg::kind_t [ddr_pkg::num_bursts-1:0]        slot_kind,
	input  ddr_pkg::mem_cmd_e                               cmd,
	input  ddr_pkg::burst_id_t                              cmd_slot,
	output logic                                            data_done,
	output logic                                            cs_n,
	output logic [13:0]                                     ca,
	output logic                                            dm_n,
	output ddr_pkg::data_t                                  dq_out,
	output logic                                            dq_oe,
	input  ddr_pkg::data_t                                  dq_in,
	output logic                                            ret_valid,
	input  logic                                            ret_ready,
	output ddr_pkg::kind_t                                  ret_kind,
	output ddr_pkg::data_t                                  ret_data,
	output ddr_pkg::index_t                                 ret_index
);
	import ddr_pkg::*;

	burst_state_e state_q [num_bursts];
	kind_t kind_q [num_bursts];
	block_t block_q [num_bursts];
	data_t data_q [num_bursts][burst_len];
	index_t index_q [num_bursts][burst_len];
	logic [burst_len-1:0] mask_q [num_bursts];
	logic [$clog2(burst_len+1)-1:0] moved_q [num_bursts];  // beats already on the bus

	burst_id_t fill_id;
	block_t req_block;
	logic [$clog2(burst_len)-1:0] req_col;
	logic [burst_len-1:0] col_onehot;
	logic [burst_len-1:0] grown_mask;
	logic accept_same;
	logic any_empty;
	logic take;
	burst_id_t open_id;
	burst_id_t wr_id;

	mem_cmd_e second_cmd;
	burst_id_t second_slot;
	logic second_pending;

	logic phase_active;
	kind_t phase_kind;
	burst_id_t phase_slot;
	logic [$clog2(rd_to_data+1)-1:0] wait_cnt;
	logic wait_done;
	logic beat_now;
	logic [$clog2(burst_len)-1:0] cur_beat;

	logic drain_found;
	burst_id_t drain_id;
	logic [$clog2(burst_len)-1:0] drain_col;

	// first CA word, sent with cs_n low
	function automatic logic [13:0] ca_first(input mem_cmd_e c, input burst_id_t s);
		block_t b;
		b = block_q[s];
		case (c)
			activate:  return {3'b000, 1'b0, b[25:24], b[23:22], b[9:6], 2'b00};  // row[3:0]
			read_cmd:  return {3'b000, 1'b0, b[25:24], b[23:22], 1'b1, 5'b11101};  // bl16
			write_cmd: return {3'b000, 1'b0, b[25:24], b[23:22], 1'b1, 5'b01101};
			precharge: return {3'b000, 1'b0, b[25:24], b[23:22], 6'b011011};
			default:   return '0;
		endcase
	endfunction

	// second CA word, cs_n back high
	function automatic logic [13:0] ca_second(input mem_cmd_e c, input burst_id_t s);
		block_t b;
		b = block_q[s];
		case (c)
			activate:  return {2'b00, b[21:10]};                          // row[15:4]
			read_cmd:  return {3'b000, 1'b1, 2'b00, b[5:0], 2'b00};        // no auto precharge
			write_cmd: return {2'b00, &mask_q[s], 1'b1, 2'b00, b[5:0], 2'b00};  // wrp_n set if full
			default:   return '0;
		endcase
	endfunction

	assign req_block = req_addr[29:4];
	assign req_col   = req_addr[3:0];

	always_comb begin
		col_onehot = '0;
		col_onehot[req_col] = 1'b1;
		any_empty = 1'b0;
		open_id = '0;
		for (int i = num_bursts-1; i >= 0; i--) begin
			if (state_q[i] == empty) begin
				any_empty = 1'b1;
				open_id = burst_id_t'(i);  // lowest empty slot wins
			end
		end
	end

	assign accept_same = (state_q[fill_id] == filling) && (block_q[fill_id] == req_block)
		&& (kind_q[fill_id] == req_kind);
	assign req_ready  = accept_same || any_empty;
	assign take       = req_valid && req_ready;
	assign wr_id      = accept_same ? fill_id : open_id;
	assign grown_mask = mask_q[fill_id] | col_onehot;

	always_comb begin
		for (int i = 0; i < num_bursts; i++) begin
			slot_state[i] = state_q[i];
			slot_kind[i]  = kind_q[i];
		end
	end

	// data phase
	assign wait_done = phase_kind ? (wait_cnt == wr_to_data) : (wait_cnt == rd_to_data);
	assign beat_now  = phase_active && wait_done;
	assign cur_beat  = moved_q[phase_slot][$clog2(burst_len)-1:0];
	assign dq_oe     = beat_now && phase_kind;
	assign dq_out    = data_q[phase_slot][cur_beat];
	assign dm_n      = !(dq_oe && !mask_q[phase_slot][cur_beat]);  // mask beats nobody wrote

	// return draining, lowest column of the lowest returning slot
	always_comb begin
		drain_found = 1'b0;
		drain_id = '0;
		for (int i = num_bursts-1; i >= 0; i--) begin
			if (state_q[i] == returning) begin
				drain_found = 1'b1;
				drain_id = burst_id_t'(i);
			end
		end
		drain_col = '0;
		for (int j = burst_len-1; j >= 0; j--) begin
			if (mask_q[drain_id][j])
				drain_col = j[$clog2(burst_len)-1:0];
		end
	end

	assign ret_valid = drain_found && mask_q[drain_id][drain_col]
		&& (moved_q[drain_id] > {1'b0, drain_col});  // only once its beat moved
	assign ret_kind  = kind_q[drain_id];
	assign ret_data  = data_q[drain_id][drain_col];
	assign ret_index = index_q[drain_id][drain_col];

	always_ff @(posedge clk) begin
		if (rst_n) begin
			for (int i = 0; i < num_bursts; i++) begin
				state_q[i] <= empty;
				mask_q[i]  <= '0;
				moved_q[i] <= '0;
			end
			fill_id        <= '0;
			cs_n           <= 1'b1;
			second_pending <= 1'b0;
			phase_active   <= 1'b0;
			phase_kind     <= 1'b0;
			phase_slot     <= '0;
			wait_cnt       <= '0;
			data_done      <= 1'b0;
		end else begin
			data_done <= 1'b0;

			if (take && accept_same) begin
				mask_q[fill_id] <= grown_mask;
				if (&grown_mask)
					state_q[fill_id] <= full;  // all beats present
			end else begin
				if (state_q[fill_id] == filling)
					state_q[fill_id] <= full;  // idle cycle or new block closes it
				if (take) begin
					state_q[open_id] <= filling;
					mask_q[open_id]  <= col_onehot;
					fill_id          <= open_id;
				end
			end

			if (ret_valid && ret_ready)
				mask_q[drain_id][drain_col] <= 1'b0;
			if (drain_found && (mask_q[drain_id] == '0) && (moved_q[drain_id] == burst_len))
				state_q[drain_id] <= empty;

			if (phase_active) begin
				if (!wait_done) begin
					wait_cnt <= wait_cnt + 1'b1;
				end else begin
					moved_q[phase_slot] <= moved_q[phase_slot] + 1'b1;
					if (moved_q[phase_slot] == '0)
						state_q[phase_slot] <= returning;  // first beat on the bus
					if (moved_q[phase_slot] == burst_len - 1) begin
						phase_active <= 1'b0;
						data_done    <= 1'b1;
					end
				end
			end

			if (cmd != none) begin
				cs_n           <= 1'b0;
				second_pending <= (cmd != precharge);  // precharge is one cycle
				if (cmd == activate)
					state_q[cmd_slot] <= issued;
			end else begin
				cs_n           <= 1'b1;
				second_pending <= 1'b0;
				if (second_pending && (second_cmd == read_cmd || second_cmd == write_cmd)) begin
					phase_active         <= 1'b1;
					phase_kind           <= (second_cmd == write_cmd);
					phase_slot           <= second_slot;
					wait_cnt             <= '0;
					moved_q[second_slot] <= '0;
				end
			end
		end
	end

	// slot payload and CA words
	always_ff @(posedge clk) begin
		if (take) begin
			data_q[wr_id][req_col]  <= req_data;
			index_q[wr_id][req_col] <= req_index;
			if (!accept_same) begin
				block_q[wr_id] <= req_block;
				kind_q[wr_id]  <= req_kind;
			end
		end
		if (beat_now && !phase_kind)
			data_q[phase_slot][cur_beat] <= dq_in;  // read beat capture
		if (cmd != none) begin
			second_cmd  <= cmd;
			second_slot <= cmd_slot;
			ca          <= ca_first(cmd, cmd_slot);
		end else if (second_pending) begin
			ca <= ca_second(second_cmd, second_slot);
		end
	end

endmodule

//--- source/timing_controller.sv
`timescale 1ns/1ps

module timing_controller (
	input  logic                                            clk,
	input  logic                                            rst_n,
	input  ddr_pkg::burst_state_e [ddr_pkg::num_bursts-1:0] slot_state,
	input  ddr_pkg::kind_t [ddr_pkg::num_bursts-1:0]        slot_kind,
	output ddr_pkg::mem_cmd_e                               cmd,
	output ddr_pkg::burst_id_t                              cmd_slot,
	input  logic                                            data_done
);
	import ddr_pkg::*;

	ctl_state_e state;
	burst_id_t sel;  // slot owning the current sequence
	logic [$clog2((t_rcd > t_rp) ? t_rcd : t_rp)-1:0] wait_cnt;  // shared by both waits
	logic full_found;
	burst_id_t full_id;

	always_comb begin
		full_found = 1'b0;
		full_id = '0;
		for (int i = num_bursts-1; i >= 0; i--) begin
			if (slot_state[i] == full) begin
				full_found = 1'b1;
				full_id = burst_id_t'(i);  // lowest full slot
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			state    <= idle;
			sel      <= '0;
			wait_cnt <= '0;
		end else begin
			case (state)
				idle: begin
					if (full_found) begin
						sel   <= full_id;
						state <= act;
					end
				end
				act: begin
					wait_cnt <= '0;
					state    <= act_wait;
				end
				act_wait: begin
					if (wait_cnt == t_rcd - 1)
						state <= col;  // row open
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				col: begin
					state <= data_phase;
				end
				data_phase: begin
					if (data_done)
						state <= pre;
				end
				pre: begin
					wait_cnt <= '0;
					state    <= pre_wait;
				end
				pre_wait: begin
					if (wait_cnt == t_rp - 1)
						state <= idle;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// one cycle per command state
	always_comb begin
		case (state)
			act:     cmd = activate;
			col:     cmd = slot_kind[sel] ? write_cmd : read_cmd;
			pre:     cmd = precharge;
			default: cmd = none;
		endcase
	end

	assign cmd_slot = sel;

endmodule

//--- source/returner.sv
`timescale 1ns/1ps

module returner (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            ret_valid,
	output logic            ret_ready,
	input  ddr_pkg::kind_t  ret_kind,
	input  ddr_pkg::data_t  ret_data,
	input  ddr_pkg::index_t ret_index,
	output logic            resp_valid,
	input  logic            resp_ready,
	output ddr_pkg::kind_t  resp_kind,
	output ddr_pkg::data_t  resp_data,
	output ddr_pkg::index_t resp_index
);
	import ddr_pkg::*;

	kind_t q_kind [ret_depth];
	data_t q_data [ret_depth];
	index_t q_index [ret_depth];
	logic [$clog2(ret_depth)-1:0] wr_ptr;
	logic [$clog2(ret_depth)-1:0] rd_ptr;
	logic [$clog2(ret_depth+1)-1:0] count;
	logic push;
	logic pop;

	assign ret_ready  = (count != ret_depth);  // full queue stalls the handler
	assign resp_valid = (count != '0);
	assign push       = ret_valid && ret_ready;
	assign pop        = resp_valid && resp_ready;

	assign resp_kind  = q_kind[rd_ptr];
	assign resp_data  = q_data[rd_ptr];
	assign resp_index = q_index[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) begin
			q_kind[wr_ptr]  <= ret_kind;
			q_data[wr_ptr]  <= ret_data;
			q_index[wr_ptr] <= ret_index;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

//--- source/ddr_channel.sv
`timescale 1ns/1ps

module ddr_channel (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            req_valid,
	output logic            req_ready,
	input  ddr_pkg::kind_t  req_kind,
	input  ddr_pkg::addr_t  req_addr,
	input  ddr_pkg::data_t  req_data,
	input  ddr_pkg::index_t req_index,
	output logic            resp_valid,
	input  logic            resp_ready,
	output ddr_pkg::kind_t  resp_kind,
	output ddr_pkg::data_t  resp_data,
	output ddr_pkg::index_t resp_index,
	output logic            cs_n,
	output logic [13:0]     ca,
	output logic            dm_n,
	output ddr_pkg::data_t  dq_out,
	output logic            dq_oe,
	input  ddr_pkg::data_t  dq_in
);
	import ddr_pkg::*;

	burst_state_e [num_bursts-1:0] slot_state;
	kind_t [num_bursts-1:0] slot_kind;
	mem_cmd_e cmd;
	burst_id_t cmd_slot;
	logic data_done;
	logic ret_valid;
	logic ret_ready;
	kind_t ret_kind;
	data_t ret_data;
	index_t ret_index;

	burst_handler burst_handler_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_kind   (req_kind),
		.req_addr   (req_addr),
		.req_data   (req_data),
		.req_index  (req_index),
		.slot_state (slot_state),
		.slot_kind  (slot_kind),
		.cmd        (cmd),
		.cmd_slot   (cmd_slot),
		.data_done  (data_done),
		.cs_n       (cs_n),
		.ca         (ca),
		.dm_n       (dm_n),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.dq_in      (dq_in),
		.ret_valid  (ret_valid),
		.ret_ready  (ret_ready),
		.ret_kind   (ret_kind),
		.ret_data   (ret_data),
		.ret_index  (ret_index)
	);

	timing_controller timing_controller_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.slot_state (slot_state),
		.slot_kind  (slot_kind),
		.cmd        (cmd),
		.cmd_slot   (cmd_slot),
		.data_done  (data_done)
	);

	returner returner_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ret_valid  (ret_valid),
		.ret_ready  (ret_ready),
		.ret_kind   (ret_kind),
		.ret_data   (ret_data),
		.ret_index  (ret_index),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_kind  (resp_kind),
		.resp_data  (resp_data),
		.resp_index (resp_index)
	);

endmodule

//--- dv/ddr_mem_model.sv
`timescale 1ns/1ps

module ddr_mem_model (
	input  logic           clk,
	input  logic           cs_n,
	input  logic [13:0]    ca,
	input  logic           dm_n,
	input  ddr_pkg::data_t dq_out,
	input  logic           dq_oe,
	output ddr_pkg::data_t dq_in
);
	import ddr_pkg::*;

	data_t mem [addr_t];     // only written words are stored
	logic [13:0] first_q;
	logic second_due;
	logic [15:0] open_row;
	addr_t base;
	int rd_wait;
	int rd_beat;
	logic rd_active;
	int wr_beat;

	// event counters read by the testbench
	int act_count;
	int wr_cmd_count;
	int masked_count;

	initial begin
		dq_in = '0;
		second_due = 1'b0;
		rd_active = 1'b0;
		act_count = 0;
		wr_cmd_count = 0;
		masked_count = 0;
		wr_beat = 0;
	end

	always @(posedge clk) begin
		if (!cs_n) begin
			first_q = ca;
			second_due = (ca[1:0] != 2'b11);  // precharge has no second word
		end else if (second_due) begin
			second_due = 1'b0;
			if (first_q[1:0] == 2'b00) begin
				open_row = {ca[11:0], first_q[5:2]};
				act_count++;
			end else if (first_q[1:0] == 2'b01) begin
				base = {first_q[9:8], first_q[7:6], open_row, ca[7:2], 4'b0000};
				if (first_q[5:2] == 4'b1111) begin
					rd_wait = rd_to_data - 1;  // dq_in is registered here
					rd_beat = 0;
					rd_active = 1'b1;
				end else begin
					wr_cmd_count++;
					wr_beat = 0;
				end
			end
		end

		if (rd_active) begin
			if (rd_wait > 0) begin
				rd_wait--;
			end else begin
				dq_in <= mem.exists(base + rd_beat) ? mem[base + rd_beat]
					: ddr_channel_tb.mem_init(base + rd_beat);
				rd_beat++;
				if (rd_beat == burst_len)
					rd_active = 1'b0;
			end
		end

		if (dq_oe) begin
			if (dm_n)
				mem[base + wr_beat] = dq_out;
			else
				masked_count++;  // beat left untouched
			wr_beat++;
		end
	end

endmodule

//--- dv/ddr_channel_props.sv
`timescale 1ns/1ps

module ddr_channel_props (
	input logic            clk,
	input logic            rst_n,
	input logic            resp_valid,
	input logic            resp_ready,
	input ddr_pkg::kind_t  resp_kind,
	input ddr_pkg::data_t  resp_data,
	input ddr_pkg::index_t resp_index,
	input logic            cs_n,
	input logic [13:0]     ca,
	input logic            dq_oe
);
	import ddr_pkg::*;

	int rd_win;  // cycles left in the current read data window
	int fail_count;  // failed assertions so far

	always @(posedge clk) begin
		if (rst_n)
			rd_win <= 0;
		else if (!cs_n && ca[1:0] == 2'b01 && ca[5:2] == 4'b1111)
			rd_win <= rd_to_data + burst_len + 2;
		else if (rd_win != 0)
			rd_win <= rd_win - 1;
	end

	assert property (@(posedge clk) disable iff (rst_n)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_kind)
			&& $stable(resp_data) && $stable(resp_index))
		else begin
			fail_count++;
			$error("response changed while stalled");
		end

	assert property (@(posedge clk) disable iff (rst_n) !(rd_win != 0 && dq_oe))
		else begin
			fail_count++;
			$error("dq_oe high in a read data phase");
		end

	assert property (@(posedge clk) disable iff (rst_n)
		!cs_n && ca[1:0] != 2'b11 |=> cs_n)
		else begin
			fail_count++;
			$error("cs_n low on two cycles in a row");
		end

endmodule

bind ddr_channel ddr_channel_props props_i (.*);

//--- dv/ddr_channel_tb.sv
`timescale 1ns/1ps

module ddr_channel_tb;
	import ddr_pkg::*;

	localparam int total_reqs = 16 + 32 + 21 + 48 + 96;
	localparam int cycle_limit = 40 * total_reqs + 2000;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_ready;
	kind_t req_kind;
	addr_t req_addr;
	data_t req_data;
	index_t req_index;
	logic resp_valid;
	logic resp_ready;
	kind_t resp_kind;
	data_t resp_data;
	index_t resp_index;
	logic cs_n;
	logic [13:0] ca;
	logic dm_n;
	data_t dq_out;
	logic dq_oe;
	data_t dq_in;

	data_t ref_mem [addr_t];
	logic pending [16];
	kind_t exp_kind [16];
	data_t exp_data [16];
	addr_t out_addr [16];
	index_t exp_order [$];  // response order for the burst test
	int outstanding;
	int errors;
	int checks;
	int cycles;
	int test_err0;
	int assert_fails;
	logic stall_on;

	ddr_channel ddr_channel_i (.*);

	ddr_mem_model mem_model_i (
		.clk    (clk),
		.cs_n   (cs_n),
		.ca     (ca),
		.dm_n   (dm_n),
		.dq_out (dq_out),
		.dq_oe  (dq_oe),
		.dq_in  (dq_in)
	);

	// background memory contents
	function automatic data_t mem_init(input addr_t a);
		return a[15:0] ^ {2'b00, a[29:16]} ^ 16'h5a3c;
	endfunction

	function automatic data_t ref_read(input addr_t a);
		return ref_mem.exists(a) ? ref_mem[a] : mem_init(a);
	endfunction

	task automatic check_data(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_index(input string name, input index_t got, input index_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_kind(input string name, input kind_t got, input kind_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("timeout: run went past %0d cycles with %0d requests open",
				cycle_limit, outstanding);
			$display("TEST FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		#2;
		resp_ready = stall_on ? 1'($urandom & 1) : 1'b1;  // random back-pressure
	end

	// scoreboard samples mid-cycle where outputs are settled
	always @(negedge clk) begin
		if (!rst_n && resp_valid && resp_ready) begin
			if (!pending[resp_index]) begin
				errors++;
				$display("response for index %0d arrived with no request open at %0t",
					resp_index, $time);
			end else begin
				check_kind("resp_kind", resp_kind, exp_kind[resp_index]);
				check_data("resp_data", resp_data, exp_data[resp_index]);
				if (exp_order.size() != 0)
					check_index("resp_index", resp_index, exp_order.pop_front());
				pending[resp_index] = 1'b0;
				outstanding--;
			end
		end
	end

	function automatic logic addr_busy(input addr_t a);
		for (int i = 0; i < 16; i++)
			if (pending[i] && out_addr[i] == a)
				return 1'b1;
		return 1'b0;
	endfunction

	// one request held until the handshake
	task automatic send_req(input kind_t k, input addr_t a, input data_t d);
		int idx;
		logic found;
		found = 1'b0;
		while (!found) begin
			for (int i = 0; i < 16; i++) begin
				if (!found && !pending[i]) begin
					idx = i;
					found = 1'b1;
				end
			end
			if (!found) begin
				@(posedge clk);
				#2;
			end
		end
		pending[idx] = 1'b1;
		out_addr[idx] = a;
		exp_kind[idx] = k;
		if (k) begin
			ref_mem[a] = d;
			exp_data[idx] = d;
		end else begin
			exp_data[idx] = ref_read(a);
		end
		outstanding++;
		req_valid = 1'b1;
		req_kind = k;
		req_addr = a;
		req_data = d;
		req_index = index_t'(idx);
		#1;
		while (!req_ready) begin
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#2;
		req_valid = 1'b0;
	endtask

	task automatic wait_drained();
		while (outstanding != 0) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic end_test(input int num, input string name);
		errors += ddr_channel_i.props_i.fail_count - assert_fails;
		assert_fails = ddr_channel_i.props_i.fail_count;
		if (errors == test_err0)
			$display("test %0d %s: passed", num, name);
		else
			$display("test %0d %s: %0d errors", num, name, errors - test_err0);
		test_err0 = errors;
	endtask

	task automatic random_reqs(input int n, input logic wide);
		addr_t a;
		kind_t k;
		for (int i = 0; i < n; i++) begin
			do begin
				if (wide)
					a = {2'($urandom), 2'($urandom), 16'($urandom % 8), 6'($urandom % 4),
						4'($urandom)};
				else
					a = {2'b00, 2'($urandom), (($urandom % 2) ? 16'h0040 : 16'h0041),
						6'($urandom % 2), 4'($urandom)};
			end while (addr_busy(a));
			k = kind_t'($urandom & 1);
			send_req(k, a, data_t'($urandom));
		end
	endtask

	initial begin
		int act0;
		int wr0;
		int mask0;
		addr_t blk;
		void'($urandom(18));
		rst_n = 1'b1;
		req_valid = 1'b0;
		req_kind = 1'b0;
		req_addr = '0;
		req_data = '0;
		req_index = '0;
		resp_ready = 1'b1;
		stall_on = 1'b0;
		outstanding = 0;
		errors = 0;
		checks = 0;
		cycles = 0;
		test_err0 = 0;
		assert_fails = 0;
		for (int i = 0; i < 16; i++)
			pending[i] = 1'b0;
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b0;
		@(negedge clk);
		check_bit("cs_n", cs_n, 1'b1);
		check_bit("dq_oe", dq_oe, 1'b0);
		check_bit("resp_valid", resp_valid, 1'b0);
		check_bit("req_ready", req_ready, 1'b1);
		end_test(1, "reset state");
		@(posedge clk);
		#2;

		// full burst of writes to one bg/bank/row/block
		blk = {2'd1, 2'd2, 16'h0123, 6'd5, 4'd0};
		act0 = mem_model_i.act_count;
		wr0 = mem_model_i.wr_cmd_count;
		for (int i = 0; i < 16; i++)
			exp_order.push_back(index_t'(i));
		for (int i = 0; i < 16; i++)
			send_req(1'b1, blk + i, data_t'($urandom));
		wait_drained();
		check_count("activate count", mem_model_i.act_count - act0, 1);
		check_count("write cmd count", mem_model_i.wr_cmd_count - wr0, 1);
		end_test(2, "full write burst");

		for (int i = 0; i < 16; i++)
			send_req(1'b0, blk + i, '0);
		for (int b = 0; b < 4; b++)
			for (int i = 0; i < 4; i++)
				send_req(1'b0, {2'(b), 2'd3, 16'h0200 + 16'(b), 6'd1, 4'(i * 3)}, '0);
		wait_drained();
		end_test(3, "read back");

		// scattered columns leave 11 masked beats
		blk = {2'd2, 2'd0, 16'h0777, 6'd9, 4'd0};
		mask0 = mem_model_i.masked_count;
		for (int i = 0; i < 5; i++)
			send_req(1'b1, blk + 1 + i * 3, data_t'($urandom));
		wait_drained();
		check_count("masked beats", mem_model_i.masked_count - mask0, 11);
		for (int i = 0; i < 16; i++)
			send_req(1'b0, blk + i, '0);
		wait_drained();
		end_test(4, "partial write mask");

		stall_on = 1'b1;
		random_reqs(48, 1'b0);
		wait_drained();
		stall_on = 1'b0;
		end_test(5, "response back-pressure");

		random_reqs(96, 1'b1);
		wait_drained();
		end_test(6, "random traffic");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- vlog.f
source/ddr_pkg.sv
source/burst_handler.sv
source/timing_controller.sv
source/returner.sv
source/ddr_channel.sv
dv/ddr_mem_model.sv
dv/ddr_channel_props.sv
dv/ddr_channel_tb.sv

//--- Bender.yml
package:
  name: ddr_channel

sources:
  - files:
      - source/ddr_pkg.sv
      - source/burst_handler.sv
      - source/timing_controller.sv
      - source/returner.sv
      - source/ddr_channel.sv
  - target: test
    files:
      - dv/ddr_mem_model.sv
      - dv/ddr_channel_props.sv
      - dv/ddr_channel_tb.sv
